// ==== verilog/rv_cfg.svh ====
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// first fetch address after reset
`define RV_PROG_ADDR_RESET 32'h0001_0000

// architectural data word and pc width
`define RV_XLEN 32

// integer register count, x0 included
`define RV_NUM_REGS 32

// edges from register read to operand response
`define RV_READ_LATENCY 3

// width of cycle and instret counters
`define RV_COUNTER_WIDTH 64

`endif

// ==== verilog/rv_arch_pkg.sv ====
`default_nettype none

`include "rv_cfg.svh"

package rv_arch_pkg;

	// data word, also used for pc
	typedef logic [`RV_XLEN-1:0] xlen_t;

	// register index
	typedef logic [$clog2(`RV_NUM_REGS)-1:0] reg_addr_t;

	// cycle and retired instruction counts
	typedef logic [`RV_COUNTER_WIDTH-1:0] counter_t;

endpackage

`default_nettype wire

// ==== verilog/operand_pkg.sv ====
`default_nettype none

package operand_pkg;

	// per operand fetch progress
	typedef enum logic [1:0] {
		SLOT_IDLE  = 2'd0,
		SLOT_WAIT  = 2'd1,
		SLOT_READY = 2'd2
	} slot_state_t;

	// one hot over operands, bit 0 is rs1 and bit 1 is rs2
	typedef logic [1:0] read_sel_t;

endpackage

`default_nettype wire

// ==== verilog/register_file.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_cfg.svh"

module register_file (
	input  wire                    clk,
	input  wire                    wr_en,
	input  wire rv_arch_pkg::reg_addr_t wr_addr,
	input  wire rv_arch_pkg::xlen_t     wr_data,
	input  wire rv_arch_pkg::reg_addr_t read_addr,
	output rv_arch_pkg::xlen_t          read_data
);

	// entry 0 is never written and never read
	rv_arch_pkg::xlen_t regs [0:`RV_NUM_REGS-1];

	always_ff @(posedge clk) begin
		if (wr_en && (wr_addr != '0)) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// x0 hardwired to zero
	always_comb begin
		if (read_addr == '0) begin
			read_data = '0;
		end else begin
			read_data = regs[read_addr];
		end
	end

endmodule

`default_nettype wire

// ==== verilog/regfile_read_pipe.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_cfg.svh"

module regfile_read_pipe (
	input  wire                         clk,
	input  wire                         resetn,
	input  wire                         rs1_req,
	input  wire                         rs2_req,
	input  wire rv_arch_pkg::reg_addr_t rs1_addr,
	input  wire rv_arch_pkg::reg_addr_t rs2_addr,
	output logic                        rs1_grant,
	output logic                        rs2_grant,
	output rv_arch_pkg::reg_addr_t      read_addr,
	input  wire rv_arch_pkg::xlen_t     read_data,
	output logic                        rs1_resp,
	output logic                        rs2_resp,
	output rv_arch_pkg::xlen_t          resp_data
);

	operand_pkg::read_sel_t grant_sel;

	// tag and data travel side by side, newest entry in index 0
	operand_pkg::read_sel_t [`RV_READ_LATENCY-1:0] tag_pipe;
	rv_arch_pkg::xlen_t [`RV_READ_LATENCY-1:0]     data_pipe;

	// fixed priority, rs1 first
	assign rs1_grant = rs1_req;
	assign rs2_grant = rs2_req && !rs1_req;

	assign grant_sel = {rs2_grant, rs1_grant};

	// one hot address mux
	assign read_addr = ({$bits(rv_arch_pkg::reg_addr_t){rs1_grant}} & rs1_addr)
		| ({$bits(rv_arch_pkg::reg_addr_t){rs2_grant}} & rs2_addr);

	always_ff @(posedge clk) begin
		if (!resetn) begin
			tag_pipe <= '0;
		end else begin
			tag_pipe <= {tag_pipe[`RV_READ_LATENCY-2:0], grant_sel};
		end
	end

	// data only matters where the tag is set
	always_ff @(posedge clk) begin
		data_pipe <= {data_pipe[`RV_READ_LATENCY-2:0], read_data};
	end

	// oldest tag becomes the response pulse
	assign rs1_resp  = tag_pipe[`RV_READ_LATENCY-1][0];
	assign rs2_resp  = tag_pipe[`RV_READ_LATENCY-1][1];
	assign resp_data = data_pipe[`RV_READ_LATENCY-1];

endmodule

`default_nettype wire

// ==== verilog/operand_slot.sv ====
`timescale 1ns/1ps
`default_nettype none

module operand_slot (
	input  wire                     clk,
	input  wire                     resetn,
	input  wire                     addr_valid,
	input  wire                     grant,
	input  wire                     resp,
	input  wire rv_arch_pkg::xlen_t resp_data,
	input  wire                     insn_complete,
	output logic                    req,
	output logic                    ready,
	output rv_arch_pkg::xlen_t      rdata
);

	operand_pkg::slot_state_t state;
	operand_pkg::slot_state_t state_next;

	always_comb begin
		state_next = state;
		case (state)
			operand_pkg::SLOT_IDLE: begin
				if (grant) begin
					state_next = operand_pkg::SLOT_WAIT;
				end
			end
			operand_pkg::SLOT_WAIT: begin
				if (resp) begin
					state_next = operand_pkg::SLOT_READY;
				end
			end
			operand_pkg::SLOT_READY: begin
				state_next = operand_pkg::SLOT_READY;
			end
			default: begin
				state_next = operand_pkg::SLOT_IDLE;
			end
		endcase
		// retiring instruction frees the slot from any state
		if (insn_complete) begin
			state_next = operand_pkg::SLOT_IDLE;
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= operand_pkg::SLOT_IDLE;
		end else begin
			state <= state_next;
		end
	end

	// operand capture on response
	always_ff @(posedge clk) begin
		if ((state == operand_pkg::SLOT_WAIT) && resp) begin
			rdata <= resp_data;
		end
	end

	assign req   = addr_valid && (state == operand_pkg::SLOT_IDLE);
	assign ready = (state == operand_pkg::SLOT_READY);

endmodule

`default_nettype wire

// ==== verilog/commit_state.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_cfg.svh"

module commit_state (
	input  wire                     clk,
	input  wire                     resetn,
	input  wire                     insn_complete,
	input  wire rv_arch_pkg::xlen_t pc_next,
	output rv_arch_pkg::xlen_t      pc,
	output rv_arch_pkg::counter_t   csr_cycle,
	output rv_arch_pkg::counter_t   csr_instret
);

	// pc advances only on retirement
	always_ff @(posedge clk) begin
		if (!resetn) begin
			pc <= `RV_PROG_ADDR_RESET;
		end else if (insn_complete) begin
			pc <= pc_next;
		end
	end

	// free running cycle count
	always_ff @(posedge clk) begin
		if (!resetn) begin
			csr_cycle <= '0;
		end else begin
			csr_cycle <= csr_cycle + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			csr_instret <= '0;
		end else if (insn_complete) begin
			csr_instret <= csr_instret + 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/rv32_regfetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv32_regfetch (
	input  wire                         clk,
	input  wire                         resetn,
	input  wire rv_arch_pkg::reg_addr_t rs1_addr,
	input  wire                         rs1_addr_valid,
	input  wire rv_arch_pkg::reg_addr_t rs2_addr,
	input  wire                         rs2_addr_valid,
	input  wire rv_arch_pkg::reg_addr_t rd_addr,
	input  wire                         rd_request,
	input  wire rv_arch_pkg::xlen_t     rd_wdata,
	input  wire rv_arch_pkg::xlen_t     pc_next,
	input  wire                         insn_complete,
	output wire rv_arch_pkg::xlen_t     rs1_rdata,
	output wire rv_arch_pkg::xlen_t     rs2_rdata,
	output wire                         rs1_ready,
	output wire                         rs2_ready,
	output wire rv_arch_pkg::xlen_t     pc,
	output wire rv_arch_pkg::counter_t  csr_cycle,
	output wire rv_arch_pkg::counter_t  csr_instret
);

	// per operand handshakes with the read pipe, bit 0 is rs1
	wire operand_pkg::read_sel_t req;
	wire operand_pkg::read_sel_t grant;
	wire operand_pkg::read_sel_t resp;

	wire rv_arch_pkg::reg_addr_t read_addr;
	wire rv_arch_pkg::xlen_t     read_data;
	wire rv_arch_pkg::xlen_t     resp_data;
	wire                         wr_en;

	// rd is written as the instruction retires
	assign wr_en = rd_request && insn_complete;

	register_file u_register_file (
		.clk       (clk),
		.wr_en     (wr_en),
		.wr_addr   (rd_addr),
		.wr_data   (rd_wdata),
		.read_addr (read_addr),
		.read_data (read_data)
	);

	regfile_read_pipe u_read_pipe (
		.clk       (clk),
		.resetn    (resetn),
		.rs1_req   (req[0]),
		.rs2_req   (req[1]),
		.rs1_addr  (rs1_addr),
		.rs2_addr  (rs2_addr),
		.rs1_grant (grant[0]),
		.rs2_grant (grant[1]),
		.read_addr (read_addr),
		.read_data (read_data),
		.rs1_resp  (resp[0]),
		.rs2_resp  (resp[1]),
		.resp_data (resp_data)
	);

	operand_slot slot_rs1 (
		.clk           (clk),
		.resetn        (resetn),
		.addr_valid    (rs1_addr_valid),
		.grant         (grant[0]),
		.resp          (resp[0]),
		.resp_data     (resp_data),
		.insn_complete (insn_complete),
		.req           (req[0]),
		.ready         (rs1_ready),
		.rdata         (rs1_rdata)
	);

	operand_slot slot_rs2 (
		.clk           (clk),
		.resetn        (resetn),
		.addr_valid    (rs2_addr_valid),
		.grant         (grant[1]),
		.resp          (resp[1]),
		.resp_data     (resp_data),
		.insn_complete (insn_complete),
		.req           (req[1]),
		.ready         (rs2_ready),
		.rdata         (rs2_rdata)
	);

	commit_state u_commit_state (
		.clk           (clk),
		.resetn        (resetn),
		.insn_complete (insn_complete),
		.pc_next       (pc_next),
		.pc            (pc),
		.csr_cycle     (csr_cycle),
		.csr_instret   (csr_instret)
	);

endmodule

`default_nettype wire

// ==== tests/tb_rv32_regfetch.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_cfg.svh"

module tb_rv32_regfetch;

	localparam int NUM_INSNS    = 300;
	localparam int WAIT_LIMIT   = 20;
	localparam int DRIVE_DELAY  = 2;

	logic                   clk;
	logic                   resetn;
	rv_arch_pkg::reg_addr_t rs1_addr;
	logic                   rs1_addr_valid;
	rv_arch_pkg::reg_addr_t rs2_addr;
	logic                   rs2_addr_valid;
	rv_arch_pkg::reg_addr_t rd_addr;
	logic                   rd_request;
	rv_arch_pkg::xlen_t     rd_wdata;
	rv_arch_pkg::xlen_t     pc_next;
	logic                   insn_complete;
	rv_arch_pkg::xlen_t     rs1_rdata;
	rv_arch_pkg::xlen_t     rs2_rdata;
	logic                   rs1_ready;
	logic                   rs2_ready;
	rv_arch_pkg::xlen_t     pc;
	rv_arch_pkg::counter_t  csr_cycle;
	rv_arch_pkg::counter_t  csr_instret;

	// reference model state
	rv_arch_pkg::xlen_t    model_regs [0:`RV_NUM_REGS-1];
	rv_arch_pkg::xlen_t    model_pc;
	rv_arch_pkg::counter_t model_cycle;
	rv_arch_pkg::counter_t model_instret;

	integer seed;

	rv32_regfetch UUT (
		.clk            (clk),
		.resetn         (resetn),
		.rs1_addr       (rs1_addr),
		.rs1_addr_valid (rs1_addr_valid),
		.rs2_addr       (rs2_addr),
		.rs2_addr_valid (rs2_addr_valid),
		.rd_addr        (rd_addr),
		.rd_request     (rd_request),
		.rd_wdata       (rd_wdata),
		.pc_next        (pc_next),
		.insn_complete  (insn_complete),
		.rs1_rdata      (rs1_rdata),
		.rs2_rdata      (rs2_rdata),
		.rs1_ready      (rs1_ready),
		.rs2_ready      (rs2_ready),
		.pc             (pc),
		.csr_cycle      (csr_cycle),
		.csr_instret    (csr_instret)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#20 clk = ~clk;
		end
	end

	task automatic check_word(input string name, input rv_arch_pkg::xlen_t actual,
			input rv_arch_pkg::xlen_t expected);
		if (actual !== expected) begin
			$display("MISMATCH %s: got 0x%h, expected 0x%h", name, actual, expected);
			$display("sim failed");
			$fatal(1, "stopping at first error");
		end
	endtask

	task automatic check_counter(input string name, input rv_arch_pkg::counter_t actual,
			input rv_arch_pkg::counter_t expected);
		if (actual !== expected) begin
			$display("MISMATCH %s: got 0x%h, expected 0x%h", name, actual, expected);
			$display("sim failed");
			$fatal(1, "stopping at first error");
		end
	endtask

	task automatic check_flag(input string name, input logic actual, input bit expected);
		if (actual !== expected) begin
			$display("MISMATCH %s: got 0x%h, expected 0x%h", name, actual, expected);
			$display("sim failed");
			$fatal(1, "stopping at first error");
		end
	endtask

	task automatic report_timeout(input string what);
		$display("timeout: %s did not become ready within %0d cycles", what, WAIT_LIMIT);
		$display("sim failed");
		$fatal(1, "stopping on timeout");
	endtask

	// one clock, then settle past the edge where outputs are stable
	task automatic next_cycle();
		@(posedge clk);
		#DRIVE_DELAY;
		model_cycle = model_cycle + 1'b1;
	endtask

	// drive one instruction, watch operand timing, then retire it
	task automatic run_insn(input bit v1, input bit v2,
			input rv_arch_pkg::reg_addr_t a1, input rv_arch_pkg::reg_addr_t a2,
			input rv_arch_pkg::reg_addr_t rd, input bit rd_req,
			input rv_arch_pkg::xlen_t wdata, input rv_arch_pkg::xlen_t pcn);
		int  waited;
		int  lat1;
		int  lat2;
		bit  exp1;
		bit  exp2;
		bit  done;
		rs1_addr       = a1;
		rs1_addr_valid = v1;
		rs2_addr       = a2;
		rs2_addr_valid = v2;
		rd_addr        = rd;
		rd_request     = rd_req;
		rd_wdata       = wdata;
		pc_next        = pcn;
		// grant edge is the first one, rs2 loses one cycle to rs1
		lat1   = `RV_READ_LATENCY + 1;
		lat2   = v1 ? `RV_READ_LATENCY + 2 : `RV_READ_LATENCY + 1;
		waited = 0;
		done   = !v1 && !v2;
		while (!done) begin
			if (waited >= WAIT_LIMIT) begin
				report_timeout(v1 && !rs1_ready ? "rs1 operand" : "rs2 operand");
			end
			next_cycle();
			waited = waited + 1;
			exp1 = v1 && (waited >= lat1);
			exp2 = v2 && (waited >= lat2);
			check_flag("rs1_ready", rs1_ready, exp1);
			check_flag("rs2_ready", rs2_ready, exp2);
			if (exp1) begin
				check_word("rs1_rdata", rs1_rdata, model_regs[a1]);
			end
			if (exp2) begin
				check_word("rs2_rdata", rs2_rdata, model_regs[a2]);
			end
			done = (!v1 || exp1) && (!v2 || exp2);
		end
		insn_complete = 1'b1;
		next_cycle();
		insn_complete = 1'b0;
		if (rd_req && (rd != '0)) begin
			model_regs[rd] = wdata;
		end
		model_pc      = pcn;
		model_instret = model_instret + 1'b1;
		check_flag("rs1_ready", rs1_ready, 1'b0);
		check_flag("rs2_ready", rs2_ready, 1'b0);
		check_word("pc", pc, model_pc);
		check_counter("csr_instret", csr_instret, model_instret);
		check_counter("csr_cycle", csr_cycle, model_cycle);
	endtask

	initial begin
		logic [31:0] rnd;
		bit          v1;
		bit          v2;
		bit          rd_req;
		rv_arch_pkg::reg_addr_t a1;
		rv_arch_pkg::reg_addr_t a2;
		rv_arch_pkg::reg_addr_t rd;
		rv_arch_pkg::xlen_t     wdata;
		rv_arch_pkg::xlen_t     pcn;
		seed           = 32'hc502;
		resetn         = 1'b0;
		rs1_addr       = '0;
		rs1_addr_valid = 1'b0;
		rs2_addr       = '0;
		rs2_addr_valid = 1'b0;
		rd_addr        = '0;
		rd_request     = 1'b0;
		rd_wdata       = '0;
		pc_next        = '0;
		insn_complete  = 1'b0;
		for (int i = 0; i < `RV_NUM_REGS; i++) begin
			model_regs[i] = '0;
		end
		model_pc      = `RV_PROG_ADDR_RESET;
		model_cycle   = '0;
		model_instret = '0;

		repeat (5) @(posedge clk);
		#DRIVE_DELAY;
		resetn      = 1'b1;
		model_cycle = '0;
		check_flag("rs1_ready", rs1_ready, 1'b0);
		check_flag("rs2_ready", rs2_ready, 1'b0);
		check_word("pc", pc, model_pc);
		check_counter("csr_cycle", csr_cycle, model_cycle);
		check_counter("csr_instret", csr_instret, model_instret);

		// fill every register once so later reads are defined
		for (int r = 1; r < `RV_NUM_REGS; r++) begin
			wdata = $random(seed);
			pcn   = $random(seed);
			run_insn(1'b0, 1'b0, '0, '0, r[4:0], 1'b1, wdata, pcn);
		end

		for (int n = 0; n < NUM_INSNS; n++) begin
			rnd    = $random(seed);
			v1     = rnd[0];
			v2     = rnd[1];
			rd_req = rnd[2];
			a1     = rnd[12:8];
			a2     = rnd[20:16];
			rd     = rnd[28:24];
			// extra weight on x0 as source and destination
			if (rnd[7:5] == 3'd0) begin
				rd = '0;
			end
			if (rnd[31:29] == 3'd0) begin
				a1 = '0;
			end
			wdata = $random(seed);
			pcn   = $random(seed);
			run_insn(v1, v2, a1, a2, rd, rd_req, wdata, pcn);
		end

		$display("sim passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+verilog
verilog/rv_arch_pkg.sv
verilog/operand_pkg.sv
verilog/register_file.sv
verilog/regfile_read_pipe.sv
verilog/operand_slot.sv
verilog/commit_state.sv
verilog/rv32_regfetch.sv
tests/tb_rv32_regfetch.sv

// ==== Bender.yml ====
package:
  name: rv32_regfetch

export_include_dirs:
  - verilog

sources:
  - files:
      # packages first, then leaf modules, then the top
      - verilog/rv_arch_pkg.sv
      - verilog/operand_pkg.sv
      - verilog/register_file.sv
      - verilog/regfile_read_pipe.sv
      - verilog/operand_slot.sv
      - verilog/commit_state.sv
      - verilog/rv32_regfetch.sv

  - target: test
    include_dirs:
      - verilog
    files:
      - tests/tb_rv32_regfetch.sv
